// File: src.f
source/irf_pkg.sv
source/irf_window_map.sv
source/irf_addr_front.sv
source/irf_thread_bank.sv
source/irf_read_mux.sv
source/irf_top.sv
tests/irf_tb.sv

// File: tests/irf_tb.sv
`timescale 1ns/1ps
`default_nettype none

module irf_tb
   import irf_pkg::*;
();

   localparam int WATCHDOG_NS = 6 * 400 * 100;  // 6 tests of 400 cycles at 100 ns

   logic                  rclk;
   logic                  reset_l;
   irf_rd_req_t           rd_req;
   irf_wr_dest_t          wr_dest0;
   irf_wr_dest_t          wr_dest1;
   irf_wr_data_t          wr_cmd0;
   irf_wr_data_t          wr_cmd1;
   irf_gswap_t            gswap;
   cwp_vec_t              cwp;
   logic                  rst_tri_en;
   logic [IRF_DATA_W-1:0] rs1_data_l;
   logic [IRF_DATA_W-1:0] rs2_data_l;
   logic [IRF_DATA_W-1:0] rs3_data_l;
   logic [IRF_HALF_W-1:0] rs3h_data_l;

   logic [IRF_DATA_W-1:0] shadow  [IRF_THREADS][IRF_DEPTH];  // expected bank contents
   bit                    written [IRF_THREADS][IRF_DEPTH];
   cwp_t                  gset_m  [IRF_THREADS];             // expected global sets
   integer                seed;
   int                    errors;
   int                    checks;

   irf_top irf_top_inst (
      .rclk        (rclk),
      .reset_l     (reset_l),
      .rd_req      (rd_req),
      .wr_dest0    (wr_dest0),
      .wr_dest1    (wr_dest1),
      .wr_cmd0     (wr_cmd0),
      .wr_cmd1     (wr_cmd1),
      .gswap       (gswap),
      .cwp         (cwp),
      .rst_tri_en  (rst_tri_en),
      .rs1_data_l  (rs1_data_l),
      .rs2_data_l  (rs2_data_l),
      .rs3_data_l  (rs3_data_l),
      .rs3h_data_l (rs3h_data_l)
   );

   initial
   begin
      rclk = 1'b0;
   end

   always #50 rclk = ~rclk;

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: the tests did not finish in %0d ns", WATCHDOG_NS);
      $display("Result: FAILED");
      $finish;
   end

   // expected bank entry from the window rule
   function automatic bank_addr_t exp_addr(input reg_spec_t spec, input tid_t tid);
      cwp_t      w;
      reg_spec_t s;
      int        a;
      w = (spec[4:3] == 2'b00) ? gset_m[tid] : cwp[tid];
      s = spec;
      if (!w[0] && spec[3])
      begin
         s[4] = ~s[4];                       // outs and ins trade places
      end
      a = s + 16 * w;
      if (spec[4:3] != 2'b00)
      begin
         a = a + 64;
      end
      return bank_addr_t'(a);
   endfunction

   function automatic logic [IRF_DATA_W-1:0] rand_word();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      a = $random(seed);
      b = $random(seed);
      c = $random(seed);
      return {a[7:0], b, c};
   endfunction

   task automatic next_cycle();
      @(posedge rclk);
      #10;
   endtask

   task automatic apply_reset();
      reset_l = 1'b0;
      repeat (3) @(posedge rclk);
      #10;
      reset_l = 1'b1;
      foreach (gset_m[t])
      begin
         gset_m[t] = cwp_t'(IRF_GSET_RESET);
      end
      foreach (written[t, a])
      begin
         written[t][a] = 1'b0;                // bank contents undefined again
      end
   endtask

   task automatic compare_word(input logic [IRF_DATA_W-1:0] got,
                               input logic [IRF_DATA_W-1:0] exp, input string what);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic update_shadow(input tid_t tid, input reg_spec_t rd,
                                input logic [IRF_DATA_W-1:0] data);
      bank_addr_t a;
      if (rd != 5'd0 && !rst_tri_en)
      begin
         a = exp_addr(rd, tid);
         shadow[tid][a]  = data;
         written[tid][a] = 1'b1;
      end
   endtask

   // destination goes one cycle ahead of enable and data
   task automatic write_ports(input logic en0, input tid_t tid0, input reg_spec_t rd0,
                              input logic [IRF_DATA_W-1:0] d0,
                              input logic en1, input tid_t tid1, input reg_spec_t rd1,
                              input logic [IRF_DATA_W-1:0] d1);
      logic w2_wins;
      w2_wins = en1 && (rd1 != 5'd0) && (tid0 == tid1);
      next_cycle();
      wr_dest0 = '{tid0, rd0};
      wr_dest1 = '{tid1, rd1};
      next_cycle();
      wr_cmd0 = '{en0, d0};
      wr_cmd1 = '{en1, d1};
      if (en0 && !w2_wins)
      begin
         update_shadow(tid0, rd0, d0);
      end
      if (en1)
      begin
         update_shadow(tid1, rd1, d1);
      end
      next_cycle();
      wr_cmd0.en = 1'b0;
      wr_cmd1.en = 1'b0;
   endtask

   task automatic write_reg(input int port, input tid_t tid, input reg_spec_t rd,
                            input logic [IRF_DATA_W-1:0] data);
      if (port == 0)
      begin
         write_ports(1'b1, tid, rd, data, 1'b0, tid, rd, '0);
      end
      else
      begin
         write_ports(1'b0, tid, rd, '0, 1'b1, tid, rd, data);
      end
   endtask

   task automatic swap_globals(input tid_t tid, input logic [1:0] agp);
      next_cycle();
      gswap = '{1'b1, tid, agp};
      if (!rst_tri_en)
      begin
         gset_m[tid] = {1'b0, agp};
      end
      next_cycle();
      gswap.en = 1'b0;
   endtask

   // only entries with a known expected value are compared
   task automatic read_check(input tid_t tid, input reg_spec_t s1, input reg_spec_t s2,
                             input reg_spec_t s3);
      bank_addr_t      a1;
      bank_addr_t      a2;
      bank_addr_t      a3;
      bank_addr_t      ah;
      logic [IRF_HALF_W-1:0] exph;
      string           tag;
      next_cycle();
      rd_req = '{tid, s1, s2, s3, 1'b1, 1'b1, 1'b1};
      a1 = exp_addr(s1, tid);
      a2 = exp_addr(s2, tid);
      a3 = exp_addr(s3, tid);
      ah = exp_addr({s3[4:1], 1'b1}, tid);   // odd partner
      next_cycle();
      rd_req.ren1 = 1'b0;
      rd_req.ren2 = 1'b0;
      rd_req.ren3 = 1'b0;
      tag = $sformatf("thread %0d r%0d r%0d r%0d", tid, s1, s2, s3);
      if (written[tid][a1])
         compare_word(rs1_data_l, ~shadow[tid][a1], {tag, " rs1"});
      if (written[tid][a2])
         compare_word(rs2_data_l, ~shadow[tid][a2], {tag, " rs2"});
      if (written[tid][a3])
         compare_word(rs3_data_l, ~shadow[tid][a3], {tag, " rs3"});
      if (written[tid][ah])
      begin
         exph = ~shadow[tid][ah][IRF_HALF_W-1:0];
         compare_word({40'd0, rs3h_data_l}, {40'd0, exph}, {tag, " rs3h"});
      end
   endtask

   task automatic thread_isolation();
      for (int t = 0; t < IRF_THREADS; t++)
      begin
         write_reg(0, tid_t'(t), 5'd9, rand_word());
         write_reg(0, tid_t'(t), 5'd18, rand_word());
         write_reg(0, tid_t'(t), 5'd27, rand_word());
      end
      for (int t = 0; t < IRF_THREADS; t++)
      begin
         read_check(tid_t'(t), 5'd9, 5'd18, 5'd27);
      end
   endtask

   task automatic window_mapping();
      logic [IRF_DATA_W-1:0] r0_data;
      for (int c = 2; c <= 3; c++)
      begin
         cwp[1] = cwp_t'(c);
         for (int s = 8; s < 32; s++)
         begin
            write_reg(0, 2'd1, reg_spec_t'(s), rand_word());
         end
      end
      r0_data = rand_word();
      write_reg(0, 2'd1, 5'd0, r0_data);     // r0 stays unwritten
      read_check(2'd1, 5'd0, 5'd0, 5'd0);
      checks++;
      assert (rs1_data_l !== ~r0_data)
      else
      begin
         errors++;
         $display("CHECK FAILED at %0t ns: thread 1 r0 holds written data %h",
                  $time, r0_data);
      end
      for (int c = 2; c <= 4; c++)
      begin
         cwp[1] = cwp_t'(c);                  // window 4 ins alias window 3
         for (int i = 8; i < 16; i++)
         begin
            read_check(2'd1, reg_spec_t'(i), reg_spec_t'(i + 8), reg_spec_t'(i + 16));
         end
      end
   endtask

   task automatic alternate_globals();
      apply_reset();
      for (int g = 1; g < 4; g++)
         write_reg(0, 2'd0, reg_spec_t'(g), rand_word());
      for (int g = 1; g < 8; g++)
         write_reg(1, 2'd2, reg_spec_t'(g), rand_word());
      swap_globals(2'd2, 2'd1);
      for (int g = 1; g < 8; g++)
         write_reg(0, 2'd2, reg_spec_t'(g), rand_word());
      read_check(2'd2, 5'd1, 5'd2, 5'd3);
      read_check(2'd2, 5'd4, 5'd5, 5'd6);
      swap_globals(2'd2, 2'd3);
      read_check(2'd2, 5'd1, 5'd2, 5'd3);
      read_check(2'd2, 5'd4, 5'd5, 5'd6);
      read_check(2'd2, 5'd7, 5'd7, 5'd7);
      read_check(2'd0, 5'd1, 5'd2, 5'd3);
   endtask

   task automatic dual_write();
      write_ports(1'b1, 2'd0, 5'd10, rand_word(), 1'b1, 2'd1, 5'd10, rand_word());
      write_reg(0, 2'd2, 5'd12, rand_word());
      write_ports(1'b1, 2'd2, 5'd12, rand_word(), 1'b1, 2'd2, 5'd13, rand_word());
      write_ports(1'b1, 2'd2, 5'd14, rand_word(), 1'b1, 2'd2, 5'd14, rand_word());
      read_check(2'd0, 5'd10, 5'd10, 5'd10);
      read_check(2'd1, 5'd10, 5'd10, 5'd10);
      read_check(2'd2, 5'd12, 5'd13, 5'd14);
   endtask

   task automatic rs3h_and_hold();
      logic [IRF_DATA_W-1:0] h1;
      logic [IRF_DATA_W-1:0] h2;
      logic [IRF_DATA_W-1:0] h3;
      logic [IRF_HALF_W-1:0] hh;
      write_reg(0, 2'd3, 5'd16, rand_word());
      write_reg(1, 2'd3, 5'd17, rand_word());
      write_reg(0, 2'd3, 5'd20, rand_word());
      read_check(2'd3, 5'd20, 5'd17, 5'd16);
      h1 = ~shadow[3][exp_addr(5'd20, 2'd3)];
      h2 = ~shadow[3][exp_addr(5'd17, 2'd3)];
      h3 = ~shadow[3][exp_addr(5'd16, 2'd3)];
      hh = ~shadow[3][exp_addr(5'd17, 2'd3)][IRF_HALF_W-1:0];
      rd_req = '{2'd0, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 1'b0};
      write_reg(0, 2'd3, 5'd20, rand_word());  // registers hold across a write
      compare_word(rs1_data_l, h1, "hold rs1");
      compare_word(rs2_data_l, h2, "hold rs2");
      compare_word(rs3_data_l, h3, "hold rs3");
      compare_word({40'd0, rs3h_data_l}, {40'd0, hh}, "hold rs3h");
   endtask

   task automatic test_mode_block();
      write_reg(0, 2'd0, 5'd9, rand_word());
      next_cycle();
      rst_tri_en = 1'b1;
      write_reg(0, 2'd0, 5'd1, rand_word());
      write_reg(1, 2'd0, 5'd9, rand_word());
      swap_globals(2'd0, 2'd2);
      next_cycle();
      rst_tri_en = 1'b0;
      read_check(2'd0, 5'd1, 5'd2, 5'd9);
   endtask

   initial
   begin
      seed       = 97610;
      errors     = 0;
      checks     = 0;
      rst_tri_en = 1'b0;
      rd_req     = '0;
      wr_dest0   = '0;
      wr_dest1   = '0;
      wr_cmd0    = '0;
      wr_cmd1    = '0;
      gswap      = '0;
      cwp        = {3'd6, 3'd3, 3'd1, 3'd4};  // threads 3..0
      apply_reset();
      thread_isolation();
      window_mapping();
      alternate_globals();
      dual_write();
      rs3h_and_hold();
      test_mode_block();
      $display("irf_tb finished: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("Result: PASSED");
      end
      else
      begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: source/irf_top.sv
`timescale 1ns/1ps
`default_nettype none

// four-thread windowed integer register file
module irf_top
   import irf_pkg::*;
(
   input  logic                  rclk,
   input  logic                  reset_l,

   input  irf_rd_req_t           rd_req,        // one read per cycle
   input  irf_wr_dest_t          wr_dest0,      // w destination, a cycle early
   input  irf_wr_dest_t          wr_dest1,      // w2 destination
   input  irf_wr_data_t          wr_cmd0,       // w enable and data
   input  irf_wr_data_t          wr_cmd1,       // w2 enable and data
   input  irf_gswap_t            gswap,
   input  cwp_vec_t              cwp,
   input  logic                  rst_tri_en,    // test mode write block

   output logic [IRF_DATA_W-1:0] rs1_data_l,
   output logic [IRF_DATA_W-1:0] rs2_data_l,
   output logic [IRF_DATA_W-1:0] rs3_data_l,
   output logic [IRF_HALF_W-1:0] rs3h_data_l
);

   bank_wr_t              bank_wr   [IRF_THREADS];
   bank_rd_t              bank_rd   [IRF_THREADS];
   logic [IRF_DATA_W-1:0] bank_dout [IRF_THREADS][4];

   irf_addr_front irf_addr_front_inst (
      .rclk       (rclk),
      .reset_l    (reset_l),
      .rd_req     (rd_req),
      .wr_dest0   (wr_dest0),
      .wr_dest1   (wr_dest1),
      .wr_cmd0    (wr_cmd0),
      .wr_cmd1    (wr_cmd1),
      .gswap      (gswap),
      .cwp        (cwp),
      .rst_tri_en (rst_tri_en),
      .bank_wr    (bank_wr),
      .bank_rd    (bank_rd)
   );

   // one private bank per thread
   for (genvar t = 0; t < IRF_THREADS; t++)
   begin : g_bank
      irf_thread_bank irf_thread_bank_inst (
         .rclk (rclk),
         .wr   (bank_wr[t]),
         .rd   (bank_rd[t]),
         .dout (bank_dout[t])
      );
   end

   irf_read_mux irf_read_mux_inst (
      .rclk        (rclk),
      .reset_l     (reset_l),
      .rd_req      (rd_req),
      .bank_dout   (bank_dout),
      .rs1_data_l  (rs1_data_l),
      .rs2_data_l  (rs2_data_l),
      .rs3_data_l  (rs3_data_l),
      .rs3h_data_l (rs3h_data_l)
   );

endmodule

`default_nettype wire

// File: source/irf_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module irf_read_mux
   import irf_pkg::*;
(
   input  logic                  rclk,
   input  logic                  reset_l,
   input  irf_rd_req_t           rd_req,
   input  logic [IRF_DATA_W-1:0] bank_dout [IRF_THREADS][4],
   output logic [IRF_DATA_W-1:0] rs1_data_l,
   output logic [IRF_DATA_W-1:0] rs2_data_l,
   output logic [IRF_DATA_W-1:0] rs3_data_l,
   output logic [IRF_HALF_W-1:0] rs3h_data_l
);

   logic any_ren;
   tid_t rd_tid_d;                           // thread the outputs show

   assign any_ren = rd_req.ren1 | rd_req.ren2 | rd_req.ren3;

   always_ff @(posedge rclk or negedge reset_l)
   begin
      if (!reset_l)
      begin
         rd_tid_d <= '0;
      end
      else if (any_ren)
      begin
         rd_tid_d <= rd_req.tid;
      end
   end

   // bypass logic wants active low data
   always_comb
   begin
      rs1_data_l  = ~bank_dout[rd_tid_d][0];
      rs2_data_l  = ~bank_dout[rd_tid_d][1];
      rs3_data_l  = ~bank_dout[rd_tid_d][2];
      rs3h_data_l = ~bank_dout[rd_tid_d][3][IRF_HALF_W-1:0];
   end

   assert property (@(posedge rclk) disable iff (!reset_l)
                    any_ren |=> !$isunknown(rd_tid_d))
      else $error("irf read thread unknown after read request");

endmodule

`default_nettype wire

// File: source/irf_thread_bank.sv
`timescale 1ns/1ps
`default_nettype none

// one thread's register storage, 1 write and 4 read ports
module irf_thread_bank
   import irf_pkg::*;
(
   input  logic                  rclk,
   input  bank_wr_t              wr,
   input  bank_rd_t              rd,
   output logic [IRF_DATA_W-1:0] dout [4]  // rs1, rs2, rs3, rs3h
);

   logic [IRF_DATA_W-1:0] mem [IRF_DEPTH];

   always_ff @(posedge rclk)
   begin
      if (wr.en)
      begin
         mem[wr.addr] <= wr.data;
      end
   end

   // reads sample the array before this edge's write lands
   always_ff @(posedge rclk)
   begin
      for (int p = 0; p < 4; p++)
      begin
         if (rd.ren[p])
         begin
            dout[p] <= mem[rd.addr[p]];    // hold when idle
         end
      end
   end

   // write address comes from the registered destination plus live cwp
   assert property (@(posedge rclk) wr.en |-> !$isunknown(wr.addr))
      else $error("irf bank write with unknown address");

endmodule

`default_nettype wire

// File: source/irf_addr_front.sv
`timescale 1ns/1ps
`default_nettype none

module irf_addr_front
   import irf_pkg::*;
(
   input  logic         rclk,
   input  logic         reset_l,
   input  irf_rd_req_t  rd_req,
   input  irf_wr_dest_t wr_dest0,             // port w
   input  irf_wr_dest_t wr_dest1,             // port w2
   input  irf_wr_data_t wr_cmd0,
   input  irf_wr_data_t wr_cmd1,
   input  irf_gswap_t   gswap,
   input  cwp_vec_t     cwp,
   input  logic         rst_tri_en,
   output bank_wr_t     bank_wr [IRF_THREADS],
   output bank_rd_t     bank_rd [IRF_THREADS]
);

   localparam int NUM_MAPS = 5;              // w, w2, rs1, rs2, rs3

   irf_wr_dest_t wr_dest0_d;
   irf_wr_dest_t wr_dest1_d;
   cwp_t         gset [IRF_THREADS];

   reg_spec_t    map_spec [NUM_MAPS];
   tid_t         map_tid  [NUM_MAPS];
   bank_addr_t   map_addr [NUM_MAPS];
   logic [NUM_MAPS-1:0] map_act;

   logic         wen0;
   logic         wen1;
   bank_addr_t   rs3h_addr;

   // destinations line up with data one cycle later
   always_ff @(posedge rclk)
   begin
      wr_dest0_d <= wr_dest0;
      wr_dest1_d <= wr_dest1;
   end

   always_ff @(posedge rclk or negedge reset_l)
   begin
      if (!reset_l)
      begin
         for (int t = 0; t < IRF_THREADS; t++)
         begin
            gset[t] <= cwp_t'(IRF_GSET_RESET);
         end
      end
      else if (gswap.en && !rst_tri_en)
      begin
         gset[gswap.tid] <= {1'b0, gswap.agp};
      end
   end

   // r0 is never written and test mode blocks all writes
   assign wen0 = wr_cmd0.en && (wr_dest0_d.rd != 5'd0) && !rst_tri_en;
   assign wen1 = wr_cmd1.en && (wr_dest1_d.rd != 5'd0) && !rst_tri_en;

   assign map_spec[0] = wr_dest0_d.rd;
   assign map_spec[1] = wr_dest1_d.rd;
   assign map_spec[2] = rd_req.rs1;
   assign map_spec[3] = rd_req.rs2;
   assign map_spec[4] = rd_req.rs3;

   assign map_tid[0] = wr_dest0_d.tid;
   assign map_tid[1] = wr_dest1_d.tid;
   assign map_tid[2] = rd_req.tid;
   assign map_tid[3] = rd_req.tid;
   assign map_tid[4] = rd_req.tid;

   assign map_act = {rd_req.ren3, rd_req.ren2, rd_req.ren1, wen1, wen0};

   for (genvar m = 0; m < NUM_MAPS; m++)
   begin : g_map
      irf_window_map irf_window_map_inst (
         .spec (map_spec[m]),
         .gset (gset[map_tid[m]]),
         .win  (cwp[map_tid[m]]),           // live window pointer
         .addr (map_addr[m])
      );

      // active ports need a known thread, window and specifier
      assert property (@(posedge rclk) disable iff (!reset_l)
                       map_act[m] |-> !$isunknown(map_addr[m]))
         else $error("irf address unknown on active port %0d", m);
   end

   // odd partner of rs3
   assign rs3h_addr = {map_addr[4][7:1], 1'b1};

   always_comb
   begin
      for (int t = 0; t < IRF_THREADS; t++)
      begin
         logic hit0;
         logic hit1;
         hit0 = wen0 && (wr_dest0_d.tid == tid_t'(t));
         hit1 = wen1 && (wr_dest1_d.tid == tid_t'(t));

         bank_wr[t].en = hit0 | hit1;
         if (hit1)
         begin
            bank_wr[t].addr = map_addr[1];  // w2 wins a same-thread clash
            bank_wr[t].data = wr_cmd1.data;
         end
         else
         begin
            bank_wr[t].addr = map_addr[0];
            bank_wr[t].data = wr_cmd0.data;
         end

         bank_rd[t].ren  = {rd_req.ren3, rd_req.ren3, rd_req.ren2, rd_req.ren1}
                           & {4{rd_req.tid == tid_t'(t)}};
         bank_rd[t].addr = {rs3h_addr, map_addr[4], map_addr[3], map_addr[2]};
      end
   end

endmodule

`default_nettype wire

// File: source/irf_window_map.sv
`timescale 1ns/1ps
`default_nettype none

// translates one architectural register number into a bank entry
module irf_window_map
   import irf_pkg::*;
(
   input  reg_spec_t  spec,
   input  cwp_t       gset,                 // thread's alternate global set
   input  cwp_t       win,                  // thread's current window
   output bank_addr_t addr
);

   logic      is_global;
   cwp_t      window;
   logic      swap_oe;
   reg_spec_t spec_adj;
   bank_addr_t win_base;
   bank_addr_t grp_base;

   // r0..r7 live in the global area
   assign is_global = (spec[4:3] == 2'b00);

   always_comb
   begin
      if (is_global)
      begin
         window = gset;
      end
      else
      begin
         window = win;
      end
   end

   // even windows keep outs and ins the other way round
   assign swap_oe = ~window[0] & spec[3];

   always_comb
   begin
      if (swap_oe)
      begin
         spec_adj = {~spec[4], spec[3:0]};
      end
      else
      begin
         spec_adj = spec;
      end
   end

   assign win_base = {1'b0, window, 4'b0000};           // 16 entries per window
   assign grp_base = is_global ? 8'd0 : 8'd64;          // windows start past globals

   assign addr = {3'b000, spec_adj} + win_base + grp_base;

endmodule

`default_nettype wire

// File: source/irf_pkg.sv
`default_nettype none

package irf_pkg;

   localparam int IRF_THREADS    = 4;
   localparam int IRF_DATA_W     = 72;      // 64 data + 8 check bits
   localparam int IRF_HALF_W     = 32;      // rs3 odd half
   localparam int IRF_DEPTH      = 208;     // 64 globals + 8x16 windows + top ins
   localparam int IRF_GSET_RESET = 3;       // normal global set

   typedef logic [1:0] tid_t;
   typedef logic [4:0] reg_spec_t;          // [4:3] group, 00 = globals
   typedef logic [2:0] cwp_t;
   typedef cwp_t [IRF_THREADS-1:0] cwp_vec_t;
   typedef logic [7:0] bank_addr_t;

   typedef struct packed {
      tid_t      tid;
      reg_spec_t rs1;
      reg_spec_t rs2;
      reg_spec_t rs3;
      logic      ren1;
      logic      ren2;
      logic      ren3;
   } irf_rd_req_t;

   typedef struct packed {
      tid_t      tid;
      reg_spec_t rd;
   } irf_wr_dest_t;                         // sent one cycle ahead of data

   typedef struct packed {
      logic                  en;
      logic [IRF_DATA_W-1:0] data;
   } irf_wr_data_t;

   typedef struct packed {
      logic       en;
      tid_t       tid;
      logic [1:0] agp;                      // new alternate global set
   } irf_gswap_t;

   typedef struct packed {
      logic                  en;
      bank_addr_t            addr;
      logic [IRF_DATA_W-1:0] data;
   } bank_wr_t;

   typedef struct packed {
      logic [3:0]       ren;                // rs3h, rs3, rs2, rs1
      bank_addr_t [3:0] addr;
   } bank_rd_t;

endpackage

`default_nettype wire
